/* mem_port_consts.svh */
`ifndef MEM_PORT_CONSTS_SVH
`define MEM_PORT_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Memory port widths
//////////////////////////////////////////////////////////////////////

// External SRAM address word
`define MEM_ADDR_W 16

// One data word per SRAM location and per cache line
`define MEM_DATA_W 16

//////////////////////////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////////////////////////

// 64 direct-mapped lines
`define CACHE_INDEX_W 6

// Remaining upper address bits
`define CACHE_TAG_W (`MEM_ADDR_W - `CACHE_INDEX_W)

`endif

/* mem_port_pkg.sv */
`include "mem_port_consts.svh"

package mem_port_pkg;

	//////////////////////////////////////////////////////////////////////
	// Address word
	//////////////////////////////////////////////////////////////////////

	// Cache view of an address
	typedef struct packed {
		logic [`CACHE_TAG_W-1:0] tag;
		logic [`CACHE_INDEX_W-1:0] index;
	} tag_index_s;

	// Raw SRAM address or tag and index
	typedef union packed {
		logic [`MEM_ADDR_W-1:0] raw;
		tag_index_s f;
	} mem_addr_u;

	//////////////////////////////////////////////////////////////////////
	// Controller encodings
	//////////////////////////////////////////////////////////////////////

	// Port sequencer states
	typedef enum logic [2:0] {
		IDLE,
		RD_SETUP,
		RD_SAMPLE,
		FILL,
		WB_WRITE,
		DONE
	} port_state_e;

	// Owner of the transaction in flight
	typedef enum logic {
		SRC_IF,
		SRC_EXE
	} req_src_e;

endpackage

/* line_cache.sv */
`timescale 1ns/1ps
`include "mem_port_consts.svh"

module line_cache (
	input logic clk,
	input logic rst,

	// Lookup and write port
	input mem_port_pkg::mem_addr_u addr,
	input logic wr,
	input logic wr_dirty,
	input logic [`MEM_DATA_W-1:0] wdata,

	// Lookup result
	output logic hit,
	output logic [`MEM_DATA_W-1:0] rdata,

	// Line currently held at addr.f.index
	output logic victim_dirty,
	output mem_port_pkg::mem_addr_u victim_addr,
	output logic [`MEM_DATA_W-1:0] victim_data
);

	localparam int LINES = 1 << `CACHE_INDEX_W;

	//////////////////////////////////////////////////////////////////////
	// Line storage
	//////////////////////////////////////////////////////////////////////

	// Per-line state bits
	logic [LINES-1:0] valid_q;
	logic [LINES-1:0] dirty_q;

	// Tag and data arrays
	logic [`CACHE_TAG_W-1:0] tag_mem [LINES];
	logic [`MEM_DATA_W-1:0] data_mem [LINES];

	// Selected line
	logic [`CACHE_INDEX_W-1:0] idx;
	logic [`CACHE_TAG_W-1:0] line_tag;
	logic [`MEM_DATA_W-1:0] line_data;
	logic line_valid;
	logic line_dirty;
	logic tag_match;

	//////////////////////////////////////////////////////////////////////
	// Combinational lookup
	//////////////////////////////////////////////////////////////////////

	assign idx = addr.f.index;
	assign line_tag = tag_mem[idx];
	assign line_data = data_mem[idx];
	assign line_valid = valid_q[idx];
	assign line_dirty = dirty_q[idx];
	assign tag_match = (line_tag == addr.f.tag);

	assign hit = line_valid & tag_match;
	assign rdata = line_data;

	// Only a modified line of another tag needs a write-back
	assign victim_dirty = line_valid & line_dirty & ~tag_match;
	assign victim_data = line_data;

	// Rebuild the victim's SRAM address from its stored tag
	always_comb begin
		victim_addr.f.tag = line_tag;
		victim_addr.f.index = idx;
	end

	//////////////////////////////////////////////////////////////////////
	// Line update
	//////////////////////////////////////////////////////////////////////

	// Valid and dirty bits
	always_ff @(posedge clk) begin
		if (!rst) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (wr) begin
			valid_q[idx] <= 1'b1;
			// EXE store marks the line, a fill leaves it clean
			dirty_q[idx] <= wr_dirty;
		end
	end

	// Tag and data install
	always_ff @(posedge clk) begin
		if (wr) begin
			tag_mem[idx] <= addr.f.tag;
			data_mem[idx] <= wdata;
		end
	end

endmodule

/* sram_port_ctrl.sv */
`timescale 1ns/1ps
`include "mem_port_consts.svh"

module sram_port_ctrl (
	input logic clk,
	input logic rst,

	// Instruction fetch requester
	input logic if_req,
	input logic [`MEM_ADDR_W-1:0] if_addr,
	output logic if_ack,
	output logic [`MEM_DATA_W-1:0] if_rdata,

	// Execute stage requester
	input logic exe_req,
	input logic exe_we,
	input logic [`MEM_ADDR_W-1:0] exe_addr,
	input logic [`MEM_DATA_W-1:0] exe_wdata,
	output logic exe_ack,
	output logic [`MEM_DATA_W-1:0] exe_rdata,

	// Cache access
	output mem_port_pkg::mem_addr_u cache_addr,
	output logic cache_wr,
	output logic cache_wr_dirty,
	output logic [`MEM_DATA_W-1:0] cache_wdata,
	input logic cache_hit,
	input logic [`MEM_DATA_W-1:0] cache_rdata,
	input logic victim_dirty,
	input mem_port_pkg::mem_addr_u victim_addr,
	input logic [`MEM_DATA_W-1:0] victim_data,

	// SRAM pins
	output logic [`MEM_ADDR_W-1:0] ram_addr,
	output logic [`MEM_DATA_W-1:0] ram_wdata,
	input logic [`MEM_DATA_W-1:0] ram_rdata,
	output logic ram_oe,
	output logic ram_we,
	output logic ram_en
);

	//////////////////////////////////////////////////////////////////////
	// Transaction state
	//////////////////////////////////////////////////////////////////////

	mem_port_pkg::port_state_e state_q;
	mem_port_pkg::req_src_e src_q;
	logic we_q;
	logic wb_need_q;
	logic ram_en_q;

	// Latched request and victim
	mem_port_pkg::mem_addr_u addr_q;
	mem_port_pkg::mem_addr_u wb_addr_q;
	logic [`MEM_DATA_W-1:0] data_q;
	logic [`MEM_DATA_W-1:0] wb_data_q;

	// Winner of arbitration in IDLE
	mem_port_pkg::mem_addr_u lookup_addr;
	logic owner_req;

	// EXE always has priority
	assign lookup_addr.raw = exe_req ? exe_addr : if_addr;

	// Req of whichever port owns the transaction
	assign owner_req = (src_q == mem_port_pkg::SRC_EXE) ? exe_req : if_req;

	//////////////////////////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			state_q <= mem_port_pkg::IDLE;
			src_q <= mem_port_pkg::SRC_IF;
			we_q <= 1'b0;
			wb_need_q <= 1'b0;
			ram_en_q <= 1'b1;
		end else begin
			ram_en_q <= 1'b0;
			case (state_q)
				mem_port_pkg::IDLE: begin
					if (exe_req || if_req) begin
						src_q <= exe_req ? mem_port_pkg::SRC_EXE : mem_port_pkg::SRC_IF;
						we_q <= exe_req & exe_we;
						// Victim state before any fill touches the line
						wb_need_q <= victim_dirty;
						if (exe_req && exe_we)
							state_q <= mem_port_pkg::FILL;
						else if (cache_hit)
							state_q <= mem_port_pkg::DONE;
						else
							state_q <= mem_port_pkg::RD_SETUP;
					end
				end
				mem_port_pkg::RD_SETUP: begin
					state_q <= mem_port_pkg::RD_SAMPLE;
				end
				mem_port_pkg::RD_SAMPLE: begin
					state_q <= mem_port_pkg::FILL;
				end
				mem_port_pkg::FILL: begin
					if (wb_need_q)
						state_q <= mem_port_pkg::WB_WRITE;
					else
						state_q <= mem_port_pkg::DONE;
				end
				mem_port_pkg::WB_WRITE: begin
					state_q <= mem_port_pkg::DONE;
				end
				mem_port_pkg::DONE: begin
					// Hold ack until the owner lets go of req
					if (!owner_req)
						state_q <= mem_port_pkg::IDLE;
				end
				default: begin
					state_q <= mem_port_pkg::IDLE;
				end
			endcase
		end
	end

	// Request payload and result word
	always_ff @(posedge clk) begin
		if (state_q == mem_port_pkg::IDLE && (exe_req || if_req)) begin
			addr_q <= lookup_addr;
			wb_addr_q <= victim_addr;
			wb_data_q <= victim_data;
			if (exe_req && exe_we)
				data_q <= exe_wdata;
			else
				data_q <= cache_rdata;
		end else if (state_q == mem_port_pkg::RD_SAMPLE) begin
			data_q <= ram_rdata;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////////////////////////

	// Handshake on the owning port only
	assign if_ack = (state_q == mem_port_pkg::DONE) && (src_q == mem_port_pkg::SRC_IF);
	assign exe_ack = (state_q == mem_port_pkg::DONE) && (src_q == mem_port_pkg::SRC_EXE);
	assign if_rdata = data_q;
	assign exe_rdata = data_q;

	// Live lookup in IDLE, then the latched address
	assign cache_addr = (state_q == mem_port_pkg::IDLE) ? lookup_addr : addr_q;
	assign cache_wr = (state_q == mem_port_pkg::FILL);
	assign cache_wr_dirty = we_q;
	assign cache_wdata = data_q;

	// SRAM strobes
	assign ram_addr = (state_q == mem_port_pkg::WB_WRITE) ? wb_addr_q.raw : addr_q.raw;
	assign ram_wdata = wb_data_q;
	assign ram_oe = !(state_q == mem_port_pkg::RD_SETUP || state_q == mem_port_pkg::RD_SAMPLE);
	assign ram_we = !(state_q == mem_port_pkg::WB_WRITE);
	assign ram_en = ram_en_q;

endmodule

/* mem_port_top.sv */
`timescale 1ns/1ps
`include "mem_port_consts.svh"

module mem_port_top (
	input logic clk,
	input logic rst,

	// Instruction fetch port
	input logic if_req,
	input logic [`MEM_ADDR_W-1:0] if_addr,
	output logic if_ack,
	output logic [`MEM_DATA_W-1:0] if_rdata,

	// Execute port
	input logic exe_req,
	input logic exe_we,
	input logic [`MEM_ADDR_W-1:0] exe_addr,
	input logic [`MEM_DATA_W-1:0] exe_wdata,
	output logic exe_ack,
	output logic [`MEM_DATA_W-1:0] exe_rdata,

	// SRAM pins
	output logic [`MEM_ADDR_W-1:0] ram_addr,
	output logic [`MEM_DATA_W-1:0] ram_wdata,
	input logic [`MEM_DATA_W-1:0] ram_rdata,
	output logic ram_oe,
	output logic ram_we,
	output logic ram_en
);

	//////////////////////////////////////////////////////////////////////
	// Controller to cache
	//////////////////////////////////////////////////////////////////////

	mem_port_pkg::mem_addr_u cache_addr;
	logic cache_wr;
	logic cache_wr_dirty;
	logic [`MEM_DATA_W-1:0] cache_wdata;
	logic cache_hit;
	logic [`MEM_DATA_W-1:0] cache_rdata;
	logic victim_dirty;
	mem_port_pkg::mem_addr_u victim_addr;
	logic [`MEM_DATA_W-1:0] victim_data;

	sram_port_ctrl sram_port_ctrl_inst (
		.clk(clk),
		.rst(rst),
		.if_req(if_req),
		.if_addr(if_addr),
		.if_ack(if_ack),
		.if_rdata(if_rdata),
		.exe_req(exe_req),
		.exe_we(exe_we),
		.exe_addr(exe_addr),
		.exe_wdata(exe_wdata),
		.exe_ack(exe_ack),
		.exe_rdata(exe_rdata),
		.cache_addr(cache_addr),
		.cache_wr(cache_wr),
		.cache_wr_dirty(cache_wr_dirty),
		.cache_wdata(cache_wdata),
		.cache_hit(cache_hit),
		.cache_rdata(cache_rdata),
		.victim_dirty(victim_dirty),
		.victim_addr(victim_addr),
		.victim_data(victim_data),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata),
		.ram_oe(ram_oe),
		.ram_we(ram_we),
		.ram_en(ram_en)
	);

	line_cache line_cache_inst (
		.clk(clk),
		.rst(rst),
		.addr(cache_addr),
		.wr(cache_wr),
		.wr_dirty(cache_wr_dirty),
		.wdata(cache_wdata),
		.hit(cache_hit),
		.rdata(cache_rdata),
		.victim_dirty(victim_dirty),
		.victim_addr(victim_addr),
		.victim_data(victim_data)
	);

endmodule

/* tb_sram_model.sv */
`timescale 1ns/1ps
`include "mem_port_consts.svh"

module tb_sram_model (
	input logic clk,
	input logic [`MEM_ADDR_W-1:0] addr,
	input logic [`MEM_DATA_W-1:0] wdata,
	output logic [`MEM_DATA_W-1:0] rdata,
	input logic oe,
	input logic we,
	input logic en
);

	localparam int WORDS = 1 << `MEM_ADDR_W;

	logic [`MEM_DATA_W-1:0] mem [WORDS];

	//////////////////////////////////////////////////////////////////////
	// Initial image
	//////////////////////////////////////////////////////////////////////

	// Every word starts as its address XOR a fixed pattern
	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem[i] <= 16'(i) ^ 16'hA5C3;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Access
	//////////////////////////////////////////////////////////////////////

	// Output driven only while enabled and output-enabled
	assign rdata = (!oe && !en) ? mem[addr] : '0;

	// Store on the edge that sees both strobes low
	always @(posedge clk) begin
		if (!we && !en) begin
			mem[addr] <= wdata;
		end
	end

endmodule

/* tb_mem_port.sv */
`timescale 1ns/1ps
`include "mem_port_consts.svh"

module tb_mem_port;

	logic clk = 1'b0;
	logic rst;
	logic if_req;
	logic [`MEM_ADDR_W-1:0] if_addr;
	logic if_ack;
	logic [`MEM_DATA_W-1:0] if_rdata;
	logic exe_req;
	logic exe_we;
	logic [`MEM_ADDR_W-1:0] exe_addr;
	logic [`MEM_DATA_W-1:0] exe_wdata;
	logic exe_ack;
	logic [`MEM_DATA_W-1:0] exe_rdata;
	logic [`MEM_ADDR_W-1:0] ram_addr;
	logic [`MEM_DATA_W-1:0] ram_wdata;
	logic [`MEM_DATA_W-1:0] ram_rdata;
	logic ram_oe;
	logic ram_we;
	logic ram_en;

	int errors = 0;
	int n_ops = 0;
	bit loaded = 1'b0;
	int oe_pulses = 0;
	int we_pulses = 0;
	logic oe_d = 1'b1;
	logic we_d = 1'b1;
	logic if_ack_d = 1'b0;
	logic exe_ack_d = 1'b0;
	logic if_req_d = 1'b0;
	logic exe_req_d = 1'b0;

	// Expected memory contents
	logic [`MEM_DATA_W-1:0] ref_mem [1 << `MEM_ADDR_W];

	// Operations from the data file
	logic [15:0] op_kind [$];
	logic [15:0] op_addr [$];
	logic [15:0] op_wdata [$];
	logic [15:0] op_exp [$];
	logic [15:0] op_oe [$];
	logic [15:0] op_we [$];

	always #2 clk = ~clk;

	mem_port_top mem_port_top_inst (
		.clk(clk), .rst(rst),
		.if_req(if_req), .if_addr(if_addr), .if_ack(if_ack), .if_rdata(if_rdata),
		.exe_req(exe_req), .exe_we(exe_we), .exe_addr(exe_addr), .exe_wdata(exe_wdata),
		.exe_ack(exe_ack), .exe_rdata(exe_rdata),
		.ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata),
		.ram_oe(ram_oe), .ram_we(ram_we), .ram_en(ram_en)
	);

	tb_sram_model tb_sram_model_inst (
		.clk(clk), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata),
		.oe(ram_oe), .we(ram_we), .en(ram_en)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Bus monitor
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (rst) begin
			if (!ram_oe && oe_d)
				oe_pulses++;
			if (!ram_we && we_d) begin
				we_pulses++;
				// Written-back victim must carry the latest value of its address
				assert (ram_wdata === ref_mem[ram_addr]) else begin
					$display("Mismatch at %0t: ram_wdata got %h expected %h",
						$time, ram_wdata, ref_mem[ram_addr]);
					errors++;
				end
			end
			assert (!(exe_ack_d && !exe_ack && exe_req_d)) else begin
				$display("Error at %0t: exe_ack fell while exe_req was high", $time);
				errors++;
			end
			assert (!(if_ack_d && !if_ack && if_req_d)) else begin
				$display("Error at %0t: if_ack fell while if_req was high", $time);
				errors++;
			end
		end
		oe_d <= ram_oe;
		we_d <= ram_we;
		if_ack_d <= if_ack;
		exe_ack_d <= exe_ack;
		if_req_d <= if_req;
		exe_req_d <= exe_req;
	end

	//////////////////////////////////////////////////////////////////////
	// Handshake helpers
	//////////////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// Waits at most 40 cycles for an ack to reach the given level
	task automatic wait_ack(input logic is_exe, input logic level);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (n < 40 && !seen) begin
			@(posedge clk);
			if ((is_exe ? exe_ack : if_ack) == level)
				seen = 1'b1;
			n++;
		end
		assert (seen) else begin
			$display("Error at %0t: %s ack did not go %0d in time",
				$time, is_exe ? "exe" : "if", level);
			errors++;
		end
	endtask

	task automatic single_access(input logic is_exe, input logic we, input logic [15:0] addr,
		input logic [15:0] wdata, input logic [15:0] exp);
		if (is_exe) begin
			exe_req <= 1'b1;
			exe_we <= we;
			exe_addr <= addr;
			exe_wdata <= wdata;
		end else begin
			if_req <= 1'b1;
			if_addr <= addr;
		end
		wait_ack(is_exe, 1'b1);
		assert (!(is_exe ? if_ack : exe_ack)) else begin
			$display("Error at %0t: the idle port was acknowledged", $time);
			errors++;
		end
		if (!we)
			check_word(is_exe ? "exe_rdata" : "if_rdata", is_exe ? exe_rdata : if_rdata, exp);
		if (is_exe)
			exe_req <= 1'b0;
		else
			if_req <= 1'b0;
		exe_we <= 1'b0;
		wait_ack(is_exe, 1'b0);
	endtask

	// Both ports request on one edge and EXE must be served first
	task automatic dual_read(input logic [15:0] addr, input logic [15:0] exp);
		exe_req <= 1'b1;
		exe_we <= 1'b0;
		exe_addr <= addr;
		if_req <= 1'b1;
		if_addr <= addr;
		wait_ack(1'b1, 1'b1);
		assert (!if_ack) else begin
			$display("Error at %0t: if_ack rose before exe_ack", $time);
			errors++;
		end
		check_word("exe_rdata", exe_rdata, exp);
		exe_req <= 1'b0;
		wait_ack(1'b1, 1'b0);
		wait_ack(1'b0, 1'b1);
		check_word("if_rdata", if_rdata, exp);
		if_req <= 1'b0;
		wait_ack(1'b0, 1'b0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int fd;
		string line;
		logic [15:0] k, a, w, e, po, pw;
		logic [31:0] rnd;
		int base_oe, base_we;
		rst <= 1'b0;
		if_req <= 1'b0;
		if_addr <= '0;
		exe_req <= 1'b0;
		exe_we <= 1'b0;
		exe_addr <= '0;
		exe_wdata <= '0;
		rnd = 32'd84231;
		for (int i = 0; i < (1 << `MEM_ADDR_W); i++)
			ref_mem[i] = 16'(i) ^ 16'hA5C3;
		fd = $fopen("mem_port_testdata.txt", "r");
		if (fd == 0) begin
			$display("Error: cannot open mem_port_testdata.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
					if ($sscanf(line, "%h %h %h %h %h %h", k, a, w, e, po, pw) == 6) begin
						op_kind.push_back(k);
						op_addr.push_back(a);
						op_wdata.push_back(w);
						op_exp.push_back(e);
						op_oe.push_back(po);
						op_we.push_back(pw);
					end
				end
			end
			$fclose(fd);
		end
		n_ops = op_kind.size();
		loaded = 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b1;
		@(posedge clk);
		assert (!if_ack && !exe_ack && ram_we && ram_oe && ram_en) else begin
			$display("Error at %0t: outputs not inactive after reset", $time);
			errors++;
		end
		for (int i = 0; i < n_ops; i++) begin
			base_oe = oe_pulses;
			base_we = we_pulses;
			case (op_kind[i])
				16'h0: single_access(1'b0, 1'b0, op_addr[i], '0, op_exp[i]);
				16'h1: single_access(1'b1, 1'b0, op_addr[i], '0, op_exp[i]);
				16'h2: begin
					ref_mem[op_addr[i]] = op_wdata[i];
					single_access(1'b1, 1'b1, op_addr[i], op_wdata[i], '0);
				end
				16'h3: dual_read(op_addr[i], op_exp[i]);
				default: begin
					// Small address window so lines conflict often
					rnd = xorshift(rnd);
					a = rnd[15:0] & 16'h01CF;
					k = rnd[31:16];
					rnd = xorshift(rnd);
					w = rnd[15:0];
					if (k[15]) begin
						ref_mem[a] = w;
						single_access(1'b1, 1'b1, a, w, '0);
					end else begin
						single_access(k[14], 1'b0, a, '0, ref_mem[a]);
					end
				end
			endcase
			if (op_oe[i] != 16'hF) begin
				assert (oe_pulses - base_oe == int'(op_oe[i])) else begin
					$display("Mismatch at %0t: ram_oe pulses got %0d expected %0d",
						$time, oe_pulses - base_oe, op_oe[i]);
					errors++;
				end
			end
			if (op_we[i] != 16'hF) begin
				assert (we_pulses - base_we == int'(op_we[i])) else begin
					$display("Mismatch at %0t: ram_we pulses got %0d expected %0d",
						$time, we_pulses - base_we, op_we[i]);
					errors++;
				end
			end
		end
		$display("Ran %0d operations, %0d errors", n_ops, errors);
		if (errors == 0 && n_ops > 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog allows 40 cycles per operation plus reset margin
	initial begin
		wait (loaded);
		repeat (n_ops * 40 + 100) @(posedge clk);
		$display("Error: run did not finish within %0d cycles", n_ops * 40 + 100);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* mem_port_testdata.txt */
# Columns: kind addr wdata expected oe_pulses we_pulses (hex, F = not checked)
# kind 0 IF read, 1 EXE read, 2 EXE write, 3 EXE and IF read on one edge, 4 random op
0 0010 0000 A5D3 1 0
0 0010 0000 A5D3 0 0
2 0010 1234 0000 0 0
0 0010 0000 1234 0 0
1 0010 0000 1234 0 0
2 0050 BEEF 0000 0 1
0 0010 0000 1234 1 1
1 0050 0000 BEEF 1 0
2 0090 DEAD 0000 0 0
2 00D0 CAFE 0000 0 1
0 0090 0000 DEAD 1 1
0 03FF 0000 A63C 1 0
3 0123 0000 A4E0 F F
3 0123 0000 A4E0 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
4 0000 0000 0000 F F
0 0010 0000 1234 F F
1 0090 0000 DEAD F F

/* mem_port.f */
+incdir+.
mem_port_pkg.sv
line_cache.sv
sram_port_ctrl.sv
mem_port_top.sv
tb_sram_model.sv
tb_mem_port.sv

/* Makefile */
# Verilator build for the memory port testbench

VERILATOR ?= verilator
TOP       := tb_mem_port
FILELIST  := mem_port.f
FLAGS     := --timing -Wno-fatal
LOG       := sim.log
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) mem_port_consts.svh
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "No result in log"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
